// File: Bender.yml
package:
  name: rob_subsystem

sources:
  - src/rob_cfg_pkg.sv
  - src/rob_types_pkg.sv
  - src/rob_ifs.sv
  - src/wb_queue.sv
  - src/cdb_arbiter.sv
  - src/rob.sv
  - src/commit_unit.sv
  - src/rob_subsystem.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_rob_subsystem.sv

// File: all.f
src/rob_cfg_pkg.sv
src/rob_types_pkg.sv
src/rob_ifs.sv
src/wb_queue.sv
src/cdb_arbiter.sv
src/rob.sv
src/commit_unit.sv
src/rob_subsystem.sv
testbench/tb_clock.sv
testbench/tb_rob_subsystem.sv

// File: src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import rob_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  alu_result_t alu_pkt_i,
    input  logic        alu_rdy_i,
    output logic        alu_pop_o,
    input  mem_result_t mem_pkt_i,
    input  logic        mem_rdy_i,
    output logic        mem_pop_o,
    cdb_if.src          cdb
);

    // high when the memory queue won last time
    logic     last_mem_q;
    logic     grant_alu;
    logic     grant_mem;
    cdb_pkt_t pkt_d;

    // mem wins when alone, or when both ready and alu went last
    assign grant_mem = mem_rdy_i && (!alu_rdy_i || !last_mem_q);
    assign grant_alu = alu_rdy_i && !grant_mem;

    // pop the winner in the broadcast cycle
    assign alu_pop_o = grant_alu;
    assign mem_pop_o = grant_mem;

    // round-robin state, only moves on a grant
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            last_mem_q <= 1'b0;
        end else if (grant_mem) begin
            last_mem_q <= 1'b1;
        end else if (grant_alu) begin
            last_mem_q <= 1'b0;
        end
    end

    // pack the chosen result onto the bus
    always_comb begin
        pkt_d = '0;
        if (grant_mem) begin
            pkt_d.from_mem = 1'b1;
            pkt_d.tag      = mem_pkt_i.tag;
            pkt_d.data     = mem_pkt_i.data;
            pkt_d.mem_addr = mem_pkt_i.mem_addr;
        end else begin
            // alu layout, branch fields included
            pkt_d.from_mem   = 1'b0;
            pkt_d.tag        = alu_pkt_i.tag;
            pkt_d.data       = alu_pkt_i.data;
            pkt_d.taken      = alu_pkt_i.taken;
            pkt_d.mispredict = alu_pkt_i.mispredict;
            pkt_d.pc_new     = alu_pkt_i.pc_new;
        end
    end

    assign cdb.valid = grant_alu || grant_mem;
    assign cdb.pkt   = pkt_d;

endmodule

// File: src/commit_unit.sv
`timescale 1ns/1ps

module commit_unit
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    commit_if.cmt                cmt,
    output logic                 retire_valid_o,
    output logic [REG_IDX_W-1:0] retire_rd_o,
    output logic                 retire_we_o,
    output logic [XLEN-1:0]      retire_data_o,
    output logic [XLEN-1:0]      retire_pc_o,
    output logic [XLEN-1:0]      retire_mem_addr_o,
    output logic                 flush_o,
    output logic [XLEN-1:0]      redirect_pc_o,
    output logic                 disp_credit_o
);

    logic retire;
    logic flush;

    // head done, retire on this edge
    assign retire = cmt.head_valid && (cmt.head_entry.status == ST_DONE);
    // mispredicted branch also kills everything younger
    assign flush  = retire && (cmt.head_entry.kind == OP_BRANCH)
                    && cmt.head_entry.mispredict;

    assign cmt.retire = retire;
    assign cmt.flush  = flush;

    // control outputs, one cycle pulses
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            flush_o        <= 1'b0;
            disp_credit_o  <= 1'b0;
        end else begin
            retire_valid_o <= retire;
            flush_o        <= flush;
            // every retired slot is a credit for dispatch
            disp_credit_o  <= retire;
        end
    end

    // retire payload, held between retires
    always_ff @(posedge clk) begin
        if (retire) begin
            retire_rd_o       <= cmt.head_entry.rd;
            retire_we_o       <= cmt.head_entry.we;
            retire_data_o     <= cmt.head_entry.data;
            retire_pc_o       <= cmt.head_entry.pc;
            retire_mem_addr_o <= cmt.head_entry.mem_addr;
        end
        // redirect target alongside flush_o
        if (flush) begin
            redirect_pc_o <= cmt.head_entry.pc_new;
        end
    end

endmodule

// File: src/rob.sv
`timescale 1ns/1ps

module rob
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter int DEPTH = ROB_DEPTH,
    parameter int IDX_W = ROB_IDX_W
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 disp_valid_i,
    input  op_kind_e             disp_kind_i,
    input  logic [XLEN-1:0]      disp_pc_i,
    input  logic [REG_IDX_W-1:0] disp_rd_i,
    input  logic                 disp_we_i,
    output logic [IDX_W-1:0]     disp_tag_o,
    cdb_if.dst                   cdb,
    commit_if.rob                cmt
);

    // circular entry table
    rob_entry_t table_q [DEPTH];

    // head is oldest, tail is next free slot
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [IDX_W-1:0] head_nxt;
    logic [IDX_W-1:0] tail_nxt;

    rob_entry_t alloc_entry;

    // wrap explicitly, depth need not be a power of two
    assign head_nxt = (head_q == IDX_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
    assign tail_nxt = (tail_q == IDX_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;

    // tag is simply the tail slot index
    assign disp_tag_o = tail_q;

    // head presentation
    assign cmt.head_entry = table_q[head_q];
    assign cmt.head_valid = table_q[head_q].valid;
    assign cmt.head_tag   = rob_tag_t'(head_q);

    // fresh entry, result fields filled on write-back
    always_comb begin
        alloc_entry        = '0;
        alloc_entry.valid  = 1'b1;
        alloc_entry.status = ST_WAIT;
        alloc_entry.kind   = disp_kind_i;
        alloc_entry.pc     = disp_pc_i;
        alloc_entry.rd     = disp_rd_i;
        alloc_entry.we     = disp_we_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || cmt.flush) begin
            // flush also beats a dispatch on this edge
            head_q <= '0;
            tail_q <= '0;
            // only control bits, payload is don't care once invalid
            for (int i = 0; i < DEPTH; i++) begin
                table_q[i].valid  <= 1'b0;
                table_q[i].status <= ST_EMPTY;
            end
        end else begin
            // write-back, tag alone identifies the slot
            if (cdb.valid) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (table_q[i].valid && (cdb.pkt.tag == rob_tag_t'(i))) begin
                        table_q[i].status <= ST_DONE;
                        table_q[i].data   <= cdb.pkt.data;
                        if (cdb.pkt.from_mem) begin
                            // load keeps its address
                            table_q[i].mem_addr <= cdb.pkt.mem_addr;
                        end else begin
                            // branch outcome
                            table_q[i].taken      <= cdb.pkt.taken;
                            table_q[i].mispredict <= cdb.pkt.mispredict;
                            table_q[i].pc_new     <= cdb.pkt.pc_new;
                        end
                    end
                end
            end

            // retire frees the head slot
            if (cmt.retire) begin
                table_q[head_q].valid  <= 1'b0;
                table_q[head_q].status <= ST_EMPTY;
                head_q                 <= head_nxt;
            end

            // allocate last, so a full rob retiring and
            // dispatching into the same slot keeps the new entry
            if (disp_valid_i) begin
                table_q[tail_q] <= alloc_entry;
                tail_q          <= tail_nxt;
            end
        end
    end

endmodule

// File: src/rob_cfg_pkg.sv
package rob_cfg_pkg;

    // sizing of the reorder buffer subsystem
    // the top level copies these into its own parameters

    // entries in the reorder buffer
    localparam int ROB_DEPTH = 32;

    // tag width, enough to name every rob entry
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    // entries per write-back queue, one queue per functional unit
    localparam int WBQ_DEPTH = 4;

    // architectural data width, rv32i
    localparam int XLEN = 32;

    // register file index width, x0..x31
    localparam int REG_IDX_W = 5;

endpackage

// File: src/rob_ifs.sv
`timescale 1ns/1ps

// common data bus, one broadcast per cycle at most
interface cdb_if
    import rob_types_pkg::*;
();

    logic     valid;
    cdb_pkt_t pkt;

    // arbiter side
    modport src (
        output valid,
        output pkt
    );

    // rob side, no back-pressure
    modport dst (
        input valid,
        input pkt
    );

endinterface

// head presentation and retire handshake between rob and commit unit
interface commit_if
    import rob_types_pkg::*;
();

    logic       head_valid;
    rob_entry_t head_entry;
    rob_tag_t   head_tag;
    // retire only while head is valid and done
    logic       retire;
    // flush wins over everything else on the same edge
    logic       flush;

    modport rob (
        output head_valid,
        output head_entry,
        output head_tag,
        input  retire,
        input  flush
    );

    modport cmt (
        input  head_valid,
        input  head_entry,
        input  head_tag,
        output retire,
        output flush
    );

endinterface

// File: src/rob_subsystem.sv
`timescale 1ns/1ps

module rob_subsystem
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter int ROB_DEPTH = rob_cfg_pkg::ROB_DEPTH,
    parameter int WBQ_DEPTH = rob_cfg_pkg::WBQ_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    // dispatch, program order
    input  logic                 disp_valid_i,
    input  op_kind_e             disp_kind_i,
    input  logic [XLEN-1:0]      disp_pc_i,
    input  logic [REG_IDX_W-1:0] disp_rd_i,
    input  logic                 disp_we_i,
    output logic [ROB_IDX_W-1:0] disp_tag_o,
    // alu and branch completion
    input  logic                 alu_valid_i,
    input  logic [ROB_IDX_W-1:0] alu_tag_i,
    input  logic [XLEN-1:0]      alu_data_i,
    input  logic                 alu_taken_i,
    input  logic                 alu_mispredict_i,
    input  logic [XLEN-1:0]      alu_pc_new_i,
    // load completion
    input  logic                 mem_valid_i,
    input  logic [ROB_IDX_W-1:0] mem_tag_i,
    input  logic [XLEN-1:0]      mem_data_i,
    input  logic [XLEN-1:0]      mem_addr_i,
    // credits
    output logic                 disp_credit_o,
    output logic                 alu_credit_o,
    output logic                 mem_credit_o,
    // retirement
    output logic                 retire_valid_o,
    output logic [REG_IDX_W-1:0] retire_rd_o,
    output logic                 retire_we_o,
    output logic [XLEN-1:0]      retire_data_o,
    output logic [XLEN-1:0]      retire_pc_o,
    output logic [XLEN-1:0]      retire_mem_addr_o,
    output logic                 flush_o,
    output logic [XLEN-1:0]      redirect_pc_o
);

    cdb_if    cdb_bus ();
    commit_if cmt_bus ();

    alu_result_t alu_res;
    alu_result_t alu_head;
    mem_result_t mem_res;
    mem_result_t mem_head;
    logic        alu_rdy;
    logic        alu_pop;
    logic        mem_rdy;
    logic        mem_pop;

    // plain ports into result structs
    assign alu_res = '{tag: alu_tag_i, data: alu_data_i, taken: alu_taken_i,
                       mispredict: alu_mispredict_i, pc_new: alu_pc_new_i};
    assign mem_res = '{tag: mem_tag_i, data: mem_data_i, mem_addr: mem_addr_i};

    // queues flush on the same edge as the rob
    wb_queue #(.payload_t(alu_result_t), .DEPTH(WBQ_DEPTH)) u_alu_wbq (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(cmt_bus.flush),
        .push_i(alu_valid_i), .push_data_i(alu_res),
        .pop_i(alu_pop), .pop_data_o(alu_head),
        .not_empty_o(alu_rdy), .credit_o(alu_credit_o)
    );

    wb_queue #(.payload_t(mem_result_t), .DEPTH(WBQ_DEPTH)) u_mem_wbq (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(cmt_bus.flush),
        .push_i(mem_valid_i), .push_data_i(mem_res),
        .pop_i(mem_pop), .pop_data_o(mem_head),
        .not_empty_o(mem_rdy), .credit_o(mem_credit_o)
    );

    cdb_arbiter u_arb (
        .clk(clk), .rst_n_i(rst_n_i),
        .alu_pkt_i(alu_head), .alu_rdy_i(alu_rdy), .alu_pop_o(alu_pop),
        .mem_pkt_i(mem_head), .mem_rdy_i(mem_rdy), .mem_pop_o(mem_pop),
        .cdb(cdb_bus.src)
    );

    // tag width fixed by the package, depth may be smaller
    rob #(.DEPTH(ROB_DEPTH), .IDX_W(ROB_IDX_W)) u_rob (
        .clk(clk), .rst_n_i(rst_n_i),
        .disp_valid_i(disp_valid_i), .disp_kind_i(disp_kind_i),
        .disp_pc_i(disp_pc_i), .disp_rd_i(disp_rd_i), .disp_we_i(disp_we_i),
        .disp_tag_o(disp_tag_o),
        .cdb(cdb_bus.dst), .cmt(cmt_bus.rob)
    );

    commit_unit u_cmt (
        .clk(clk), .rst_n_i(rst_n_i), .cmt(cmt_bus.cmt),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_we_o(retire_we_o), .retire_data_o(retire_data_o),
        .retire_pc_o(retire_pc_o), .retire_mem_addr_o(retire_mem_addr_o),
        .flush_o(flush_o), .redirect_pc_o(redirect_pc_o),
        .disp_credit_o(disp_credit_o)
    );

endmodule

// File: src/rob_types_pkg.sv
package rob_types_pkg;

    import rob_cfg_pkg::*;

    // instruction kind as seen by the rob
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_BRANCH = 2'd2
    } op_kind_e;

    // life cycle of one entry
    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0,
        ST_WAIT  = 2'd1,
        ST_DONE  = 2'd2
    } rob_status_e;

    typedef logic [ROB_IDX_W-1:0] rob_tag_t;

    // one slot of the entry table
    typedef struct packed {
        logic                 valid;
        rob_status_e          status;
        op_kind_e             kind;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 we;
        logic [XLEN-1:0]      data;
        logic [XLEN-1:0]      mem_addr;
        logic                 taken;
        logic                 mispredict;
        logic [XLEN-1:0]      pc_new;
    } rob_entry_t;

    // alu and branch unit result
    typedef struct packed {
        rob_tag_t        tag;
        logic [XLEN-1:0] data;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] pc_new;
    } alu_result_t;

    // load result, store data is not tracked
    typedef struct packed {
        rob_tag_t        tag;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] mem_addr;
    } mem_result_t;

    // common data bus payload, both layouts plus source flag
    typedef struct packed {
        logic            from_mem;
        rob_tag_t        tag;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] mem_addr;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] pc_new;
    } cdb_pkt_t;

endpackage

// File: src/wb_queue.sv
`timescale 1ns/1ps

module wb_queue
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
#(
    parameter type payload_t = alu_result_t,
    parameter int  DEPTH     = WBQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     not_empty_o,
    output logic     credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage, payload only
    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign not_empty_o = (count_q != '0);
    // oldest result sits at the read pointer
    assign pop_data_o  = mem_q[rd_ptr_q];

    // pointers, count and credit pulse
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            // flush drops queued results of discarded work
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // one credit back per forwarded result
    // entries dropped by a flush come back through flush_o instead
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
        end
    end

    // payload write
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, synchronous reset
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// File: testbench/tb_rob_subsystem.sv
`timescale 1ns/1ps

module tb_rob_subsystem
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
();

    localparam int CLK_PERIOD_NS  = 100;
    localparam int RESET_CYCLES   = 4;
    localparam int NROWS          = 40;
    localparam int TIMEOUT_CYCLES = NROWS * 40;

    // one instruction of the program and its expected retirement
    typedef struct {
        string                name;
        op_kind_e             kind;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 we;
        logic [XLEN-1:0]      data;
        logic [XLEN-1:0]      mem_addr;
        logic                 mispredict;
        logic [XLEN-1:0]      pc_new;
    } row_t;

    logic clk;
    logic rst_n;

    logic                 disp_valid;
    op_kind_e             disp_kind;
    logic [XLEN-1:0]      disp_pc;
    logic [REG_IDX_W-1:0] disp_rd;
    logic                 disp_we;
    logic [ROB_IDX_W-1:0] disp_tag;
    logic                 alu_valid;
    logic [ROB_IDX_W-1:0] alu_tag;
    logic [XLEN-1:0]      alu_data;
    logic                 alu_taken;
    logic                 alu_mispredict;
    logic [XLEN-1:0]      alu_pc_new;
    logic                 mem_valid;
    logic [ROB_IDX_W-1:0] mem_tag;
    logic [XLEN-1:0]      mem_data;
    logic [XLEN-1:0]      mem_addr;
    logic                 disp_credit;
    logic                 alu_credit;
    logic                 mem_credit;
    logic                 retire_valid;
    logic [REG_IDX_W-1:0] retire_rd;
    logic                 retire_we;
    logic [XLEN-1:0]      retire_data;
    logic [XLEN-1:0]      retire_pc;
    logic [XLEN-1:0]      retire_mem_addr;
    logic                 flush;
    logic [XLEN-1:0]      redirect_pc;

    row_t                 rows [NROWS];
    // results owed by the execution units, row index and rob tag
    int                   pend_row [$];
    logic [ROB_IDX_W-1:0] pend_tag [$];
    // cycle in which each row's result was sent or -1 while owed
    int                   done_cyc [NROWS];
    int                   cyc;
    logic [31:0]          lfsr_state;
    int                   disp_idx;
    int                   exp_idx;
    int                   disp_credits;
    int                   alu_credits;
    int                   mem_credits;
    int                   stall_cycles;
    int                   value_errors;
    int                   protocol_errors;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk_o(clk), .rst_n_o(rst_n)
    );

    rob_subsystem #(.ROB_DEPTH(ROB_DEPTH), .WBQ_DEPTH(WBQ_DEPTH)) dut (
        .clk(clk), .rst_n_i(rst_n),
        .disp_valid_i(disp_valid), .disp_kind_i(disp_kind), .disp_pc_i(disp_pc),
        .disp_rd_i(disp_rd), .disp_we_i(disp_we), .disp_tag_o(disp_tag),
        .alu_valid_i(alu_valid), .alu_tag_i(alu_tag), .alu_data_i(alu_data),
        .alu_taken_i(alu_taken), .alu_mispredict_i(alu_mispredict),
        .alu_pc_new_i(alu_pc_new),
        .mem_valid_i(mem_valid), .mem_tag_i(mem_tag), .mem_data_i(mem_data),
        .mem_addr_i(mem_addr),
        .disp_credit_o(disp_credit), .alu_credit_o(alu_credit), .mem_credit_o(mem_credit),
        .retire_valid_o(retire_valid), .retire_rd_o(retire_rd), .retire_we_o(retire_we),
        .retire_data_o(retire_data), .retire_pc_o(retire_pc),
        .retire_mem_addr_o(retire_mem_addr), .flush_o(flush), .redirect_pc_o(redirect_pc)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic int take_bits(input int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // program: loads every 4th row, branches every 6th, two of them mispredicted
    task automatic build_table();
        for (int i = 0; i < NROWS; i++) begin
            rows[i].name       = $sformatf("row%0d", i);
            rows[i].pc         = 32'h0000_1000 + 32'(i * 4);
            rows[i].rd         = REG_IDX_W'(i % 31 + 1);
            rows[i].we         = 1'b1;
            rows[i].data       = 32'hd000_0000 ^ (32'(i) * 32'h0101_0101);
            rows[i].mem_addr   = '0;
            rows[i].mispredict = 1'b0;
            // redirect target is the next row, which gets fetched again
            rows[i].pc_new     = rows[i].pc + 32'd4;
            if (i % 6 == 3) begin
                rows[i].kind       = OP_BRANCH;
                rows[i].we         = 1'b0;
                rows[i].mispredict = (i == 3) || (i == 33);
            end else if (i % 4 == 1) begin
                rows[i].kind     = OP_LOAD;
                rows[i].mem_addr = 32'h8000_0000 + 32'(i * 16);
            end else begin
                rows[i].kind = OP_ALU;
            end
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            value_errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, exp_v, act_v);
        end
    endtask

    // scoreboard and credit returns, outputs settled 1 ns after the edge
    task automatic sample_outputs();
        if (flush) begin
            assert (retire_valid) else begin
                protocol_errors++;
                $display("flush seen without an instruction retiring with it");
            end
        end
        if (retire_valid) begin
            assert (exp_idx < NROWS) else begin
                protocol_errors++;
                $display("an instruction retired after the whole program had retired");
            end
        end
        if (retire_valid && exp_idx < NROWS) begin
            // push, then done one edge later, then retire one edge after that
            // so a stale copy of a flushed row shows up too early
            assert (done_cyc[exp_idx] >= 0 && cyc >= done_cyc[exp_idx] + 3) else begin
                protocol_errors++;
                $display("%s retired before its result from the latest dispatch arrived",
                         rows[exp_idx].name);
            end
            check_value(rows[exp_idx].name, "rd", 32'(rows[exp_idx].rd), 32'(retire_rd));
            check_value(rows[exp_idx].name, "we", 32'(rows[exp_idx].we), 32'(retire_we));
            check_value(rows[exp_idx].name, "data", rows[exp_idx].data, retire_data);
            check_value(rows[exp_idx].name, "pc", rows[exp_idx].pc, retire_pc);
            if (rows[exp_idx].kind == OP_LOAD) begin
                check_value(rows[exp_idx].name, "mem_addr", rows[exp_idx].mem_addr,
                            retire_mem_addr);
            end
            check_value(rows[exp_idx].name, "flush", 32'(rows[exp_idx].mispredict),
                        32'(flush));
            if (rows[exp_idx].mispredict) begin
                check_value(rows[exp_idx].name, "redirect_pc", rows[exp_idx].pc_new,
                            redirect_pc);
            end
            exp_idx++;
        end
        if (flush) begin
            // refetch from the redirect row, all credits restored
            disp_idx     = exp_idx;
            disp_credits = ROB_DEPTH;
            alu_credits  = WBQ_DEPTH;
            mem_credits  = WBQ_DEPTH;
            pend_row.delete();
            pend_tag.delete();
        end else begin
            if (disp_credit) disp_credits++;
            if (alu_credit) alu_credits++;
            if (mem_credit) mem_credits++;
        end
    endtask

    task automatic check_credits();
        assert (disp_credits >= 0 && disp_credits <= ROB_DEPTH) else begin
            protocol_errors++;
            $display("dispatch credit balance out of range: %0d", disp_credits);
        end
        assert (alu_credits >= 0 && alu_credits <= WBQ_DEPTH) else begin
            protocol_errors++;
            $display("alu queue credit balance out of range: %0d", alu_credits);
        end
        assert (mem_credits >= 0 && mem_credits <= WBQ_DEPTH) else begin
            protocol_errors++;
            $display("memory queue credit balance out of range: %0d", mem_credits);
        end
    endtask

    // in order, one row per cycle while a credit is held
    task automatic drive_dispatch();
        disp_valid = 1'b0;
        if (disp_idx < NROWS && disp_credits == 0) begin
            stall_cycles++;
        end
        if (disp_idx < NROWS && disp_credits > 0) begin
            disp_valid = 1'b1;
            disp_kind  = rows[disp_idx].kind;
            disp_pc    = rows[disp_idx].pc;
            disp_rd    = rows[disp_idx].rd;
            disp_we    = rows[disp_idx].we;
            pend_row.push_back(disp_idx);
            pend_tag.push_back(disp_tag);
            done_cyc[disp_idx] = -1;
            disp_credits--;
            disp_idx++;
        end
    endtask

    // random delay and random pick among owed results, per unit
    task automatic drive_completion();
        int cand [$];
        int k;
        int r;
        alu_valid = 1'b0;
        mem_valid = 1'b0;
        for (int i = 0; i < pend_row.size(); i++) begin
            if (rows[pend_row[i]].kind != OP_LOAD) cand.push_back(i);
        end
        if (cand.size() > 0 && alu_credits > 0 && take_bits(2) == 0) begin
            k              = cand[take_bits(5) % cand.size()];
            r              = pend_row[k];
            alu_valid      = 1'b1;
            alu_tag        = pend_tag[k];
            alu_data       = rows[r].data;
            alu_taken      = rows[r].mispredict;
            alu_mispredict = rows[r].mispredict;
            alu_pc_new     = rows[r].pc_new;
            done_cyc[r]    = cyc;
            pend_row.delete(k);
            pend_tag.delete(k);
            alu_credits--;
        end
        cand.delete();
        for (int i = 0; i < pend_row.size(); i++) begin
            if (rows[pend_row[i]].kind == OP_LOAD) cand.push_back(i);
        end
        if (cand.size() > 0 && mem_credits > 0 && take_bits(2) == 0) begin
            k           = cand[take_bits(5) % cand.size()];
            r           = pend_row[k];
            mem_valid   = 1'b1;
            mem_tag     = pend_tag[k];
            mem_data    = rows[r].data;
            mem_addr    = rows[r].mem_addr;
            done_cyc[r] = cyc;
            pend_row.delete(k);
            pend_tag.delete(k);
            mem_credits--;
        end
    endtask

    task automatic cycle_step();
        @(posedge clk);
        #1;
        cyc++;
        sample_outputs();
        check_credits();
        drive_dispatch();
        drive_completion();
    endtask

    initial begin
        disp_valid     = 1'b0;
        disp_kind      = OP_ALU;
        disp_pc        = '0;
        disp_rd        = '0;
        disp_we        = 1'b0;
        alu_valid      = 1'b0;
        alu_tag        = '0;
        alu_data       = '0;
        alu_taken      = 1'b0;
        alu_mispredict = 1'b0;
        alu_pc_new     = '0;
        mem_valid      = 1'b0;
        mem_tag        = '0;
        mem_data       = '0;
        mem_addr       = '0;
        lfsr_state      = 32'h5762686a;
        cyc             = 0;
        disp_idx        = 0;
        exp_idx         = 0;
        disp_credits    = ROB_DEPTH;
        alu_credits     = WBQ_DEPTH;
        mem_credits     = WBQ_DEPTH;
        stall_cycles    = 0;
        value_errors    = 0;
        protocol_errors = 0;
        build_table();
        for (int i = 0; i < NROWS; i++) begin
            done_cyc[i] = -1;
        end
        @(posedge rst_n);
        assert (!retire_valid && !flush && !disp_credit && !alu_credit && !mem_credit)
        else begin
            protocol_errors++;
            $display("control outputs were not low after reset");
        end
        while (exp_idx < NROWS) begin
            cycle_step();
        end
        // last credit pulses land one cycle after their event
        repeat (4) cycle_step();
        assert (disp_credits == ROB_DEPTH && alu_credits == WBQ_DEPTH
                && mem_credits == WBQ_DEPTH) else begin
            protocol_errors++;
            $display("credits missing at the end: dispatch %0d, alu %0d, memory %0d",
                     disp_credits, alu_credits, mem_credits);
        end
        assert (stall_cycles > 0) else begin
            protocol_errors++;
            $display("dispatch never ran out of credits");
        end
        $display(
            "summary: %0d rows retired, %0d stall cycles, %0d value errors, %0d protocol errors",
            exp_idx, stall_cycles, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // bound on run time, generous per row
    initial begin
        #(CLK_PERIOD_NS * (TIMEOUT_CYCLES + RESET_CYCLES));
        $display("watchdog: run stalled, only %0d of %0d rows retired in %0d cycles",
                 exp_idx, NROWS, TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
